// File: Bender.yml
package:
  name: zxuno_io

sources:
  - files:
      - source/zxuno_pkg.sv
      - source/zxuno_addr_reg.sv
      - source/coreid_reader.sv
      - source/option_registers.sv
      - source/cpu_read_mux.sv
      - source/zxuno_io.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_zxuno_io.sv

// File: source/coreid_reader.sv
`default_nettype none

module coreid_reader (
  input  logic                   sysclk,
  input  logic                   reset,
  input  zxuno_pkg::reg_access_t reg_access,
  output zxuno_pkg::read_resp_t  resp
);

  import zxuno_pkg::*;

  localparam logic [coreid_idx_w-1:0] last_idx = coreid_idx_w'(coreid_len);

  logic                    sel;
  logic                    id_rd;
  logic                    id_rd_q;
  logic                    rd_done;
  logic [coreid_idx_w-1:0] idx;
  logic [7:0]              id_char;

  assign sel   = (reg_access.regaddr == reg_coreid);
  assign id_rd = sel && reg_access.rd;

  // Read just ended, rd low now but high last cycle
  assign rd_done = id_rd_q && !id_rd;

  // --------------------------------------------------------------------------
  // Character index
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (reset) begin
      idx     <= '0;
      id_rd_q <= 1'b0;
    end else begin
      id_rd_q <= id_rd;
      if (reg_access.addr_changed) begin
        // New register selection restarts the string
        idx <= '0;
      end else if (rd_done) begin
        if (idx == last_idx) begin
          idx <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read data
  // --------------------------------------------------------------------------

  // Terminator slot returns zero
  always_comb begin
    if (idx == last_idx) begin
      id_char = 8'h00;
    end else begin
      id_char = coreid_text[idx];
    end
  end

  always_comb begin
    resp.data = id_char;
    resp.oe   = id_rd;
  end

endmodule

`default_nettype wire

// File: source/cpu_read_mux.sv
`default_nettype none

module cpu_read_mux (
  input  zxuno_pkg::z80_io_bus_t cpu_bus,
  input  zxuno_pkg::read_resp_t  addr_resp,
  input  zxuno_pkg::read_resp_t  coreid_resp,
  input  zxuno_pkg::read_resp_t  option_resp,
  input  logic [7:0]             ula_data,
  output logic [7:0]             cpu_din
);

  import zxuno_pkg::*;

  logic intack;

  // Interrupt acknowledge, IORQ together with M1
  assign intack = !cpu_bus.iorq_n && !cpu_bus.m1_n;

  // --------------------------------------------------------------------------
  // Priority selection, ULA is the fallback
  // --------------------------------------------------------------------------
  always_comb begin
    if (intack) begin
      cpu_din = intack_data;
    end else if (addr_resp.oe) begin
      cpu_din = addr_resp.data;
    end else if (coreid_resp.oe) begin
      cpu_din = coreid_resp.data;
    end else if (option_resp.oe) begin
      cpu_din = option_resp.data;
    end else begin
      cpu_din = ula_data;
    end
  end

endmodule

`default_nettype wire

// File: source/option_registers.sv
`default_nettype none

module option_registers (
  input  logic                    sysclk,
  input  logic                    reset,
  input  zxuno_pkg::reg_access_t  reg_access,
  output zxuno_pkg::dev_options_t dev_options,
  output zxuno_pkg::read_resp_t   resp
);

  import zxuno_pkg::*;

  logic         scratch_sel;
  logic         options_sel;
  logic [7:0]   scratch;
  dev_options_u options;

  // --------------------------------------------------------------------------
  // Register select
  // --------------------------------------------------------------------------
  assign scratch_sel = (reg_access.regaddr == reg_scratch);
  assign options_sel = (reg_access.regaddr == reg_devoptions);

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  // Write repeats each cycle of the access with the same byte
  always_ff @(posedge sysclk) begin
    if (reset) begin
      scratch     <= 8'h00;
      options.raw <= 8'h00;
    end else if (reg_access.wr) begin
      if (scratch_sel) begin
        scratch <= reg_access.wdata;
      end
      if (options_sel) begin
        options.raw <= reg_access.wdata;
      end
    end
  end

  // Flags go out to the rest of the machine
  assign dev_options = options.flags;

  // --------------------------------------------------------------------------
  // Readback
  // --------------------------------------------------------------------------
  always_comb begin
    resp.oe = reg_access.rd && (scratch_sel || options_sel);
    if (options_sel) begin
      resp.data = options.raw;
    end else begin
      resp.data = scratch;
    end
  end

endmodule

`default_nettype wire

// File: source/zxuno_addr_reg.sv
`default_nettype none

module zxuno_addr_reg (
  input  logic                   sysclk,
  input  logic                   reset,
  input  zxuno_pkg::z80_io_bus_t cpu_bus,
  output zxuno_pkg::reg_access_t reg_access,
  output zxuno_pkg::read_resp_t  addr_resp
);

  import zxuno_pkg::*;

  logic       io_cycle;
  logic       io_rd;
  logic       io_wr;
  logic       addr_hit;
  logic       data_hit;
  logic       addr_wr;
  logic       addr_wr_q;
  logic       addr_changed;
  logic [7:0] regaddr;

  // --------------------------------------------------------------------------
  // Port decode
  // --------------------------------------------------------------------------

  // Plain I/O cycle, not an interrupt acknowledge
  assign io_cycle = !cpu_bus.iorq_n && cpu_bus.m1_n && cpu_bus.rfsh_n;
  assign io_rd    = io_cycle && !cpu_bus.rd_n;
  assign io_wr    = io_cycle && !cpu_bus.wr_n;

  // Full 16-bit decode of both ports
  assign addr_hit = (cpu_bus.addr == zxuno_addr_port);
  assign data_hit = (cpu_bus.addr == zxuno_data_port);

  assign addr_wr = addr_hit && io_wr;

  // --------------------------------------------------------------------------
  // Register address and change pulse
  // --------------------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (reset) begin
      regaddr      <= 8'h00;
      addr_wr_q    <= 1'b0;
      addr_changed <= 1'b0;
    end else begin
      addr_wr_q <= addr_wr;
      // Pulse follows the first cycle of the write only
      addr_changed <= addr_wr && !addr_wr_q;
      if (addr_wr) begin
        regaddr <= cpu_bus.wdata;
      end
    end
  end

  // Data port strobes are plain levels from the bus
  always_comb begin
    reg_access.regaddr      = regaddr;
    reg_access.wdata        = cpu_bus.wdata;
    reg_access.rd           = data_hit && io_rd;
    reg_access.wr           = data_hit && io_wr;
    reg_access.addr_changed = addr_changed;
  end

  // Readback of the address port
  always_comb begin
    addr_resp.data = regaddr;
    addr_resp.oe   = addr_hit && io_rd;
  end

endmodule

`default_nettype wire

// File: source/zxuno_io.sv
`default_nettype none

module zxuno_io (
  input  logic                    sysclk,
  input  logic                    reset,
  input  zxuno_pkg::z80_io_bus_t  cpu_bus,
  input  logic [7:0]              ula_data,
  output logic [7:0]              cpu_din,
  output zxuno_pkg::dev_options_t dev_options
);

  import zxuno_pkg::*;

  // Shared register access and per-target read responses
  reg_access_t reg_access;
  read_resp_t  addr_resp;
  read_resp_t  coreid_resp;
  read_resp_t  option_resp;

  // --------------------------------------------------------------------------
  // Register address port and data port strobes
  // --------------------------------------------------------------------------
  zxuno_addr_reg u_addr_reg (
    .sysclk     (sysclk),
    .reset      (reset),
    .cpu_bus    (cpu_bus),
    .reg_access (reg_access),
    .addr_resp  (addr_resp)
  );

  // --------------------------------------------------------------------------
  // Register targets
  // --------------------------------------------------------------------------
  coreid_reader u_coreid (
    .sysclk     (sysclk),
    .reset      (reset),
    .reg_access (reg_access),
    .resp       (coreid_resp)
  );

  option_registers u_options (
    .sysclk      (sysclk),
    .reset       (reset),
    .reg_access  (reg_access),
    .dev_options (dev_options),
    .resp        (option_resp)
  );

  // --------------------------------------------------------------------------
  // CPU data input
  // --------------------------------------------------------------------------
  cpu_read_mux u_read_mux (
    .cpu_bus     (cpu_bus),
    .addr_resp   (addr_resp),
    .coreid_resp (coreid_resp),
    .option_resp (option_resp),
    .ula_data    (ula_data),
    .cpu_din     (cpu_din)
  );

endmodule

`default_nettype wire

// File: source/zxuno_pkg.sv
`default_nettype none

package zxuno_pkg;

  // --------------------------------------------------------------------------
  // I/O ports of the indirect register bank
  // --------------------------------------------------------------------------
  localparam logic [15:0] zxuno_addr_port = 16'hFC3B;
  localparam logic [15:0] zxuno_data_port = 16'hFD3B;

  // Register addresses behind the data port
  localparam logic [7:0] reg_devoptions = 8'h0E;
  localparam logic [7:0] reg_scratch    = 8'hFE;
  localparam logic [7:0] reg_coreid     = 8'hFF;

  // Byte on the data bus while an interrupt is acknowledged
  localparam logic [7:0] intack_data = 8'hFF;

  // Core ID string, zero terminator is generated, not stored
  localparam int unsigned coreid_len   = 8;
  localparam int unsigned coreid_idx_w = $clog2(coreid_len + 1);
  localparam logic [0:coreid_len-1][7:0] coreid_text = "ZXUNO-01";

  // --------------------------------------------------------------------------
  // Bus and register types
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic        rfsh_n;
  } z80_io_bus_t;

  // Indirect register access as every target sees it
  typedef struct packed {
    logic [7:0] regaddr;
    logic [7:0] wdata;
    logic       rd;
    logic       wr;
    logic       addr_changed;
  } reg_access_t;

  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } read_resp_t;

  // Device enable flags, top bit first
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } dev_options_t;

  // Options word, raw for storage and readback, flags for the outputs
  typedef union packed {
    dev_options_t flags;
    logic [7:0]   raw;
  } dev_options_u;

endpackage

`default_nettype wire

// File: testbench/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// ----------------------------------------------------------------------------
// Z80 I/O bus cycles, included in the testbench module
// ----------------------------------------------------------------------------

// All strobes high
task bus_idle();
  cpu_bus.iorq_n = 1'b1;
  cpu_bus.rd_n   = 1'b1;
  cpu_bus.wr_n   = 1'b1;
  cpu_bus.m1_n   = 1'b1;
  cpu_bus.rfsh_n = 1'b1;
endtask

// Holds the strobes for 2 to 4 cycles, samples mid last cycle, then idles
task run_access(output logic [7:0] data);
  int unsigned len;
  len = $urandom_range(4, 2);
  repeat (len - 1) @(posedge sysclk);
  @(negedge sysclk);
  data = cpu_din;
  @(posedge sysclk);
  #drive_delay;
  bus_idle();
  repeat (2) @(posedge sysclk);
  #drive_delay;
endtask

task io_write(input logic [15:0] addr, input logic [7:0] data);
  logic [7:0] unused;
  cpu_bus.addr   = addr;
  cpu_bus.wdata  = data;
  ula_data       = 8'($urandom);
  cpu_bus.iorq_n = 1'b0;
  cpu_bus.wr_n   = 1'b0;
  run_access(unused);
endtask

task io_read(input logic [15:0] addr, output logic [7:0] data);
  cpu_bus.addr   = addr;
  cpu_bus.wdata  = 8'($urandom);
  ula_data       = 8'($urandom);
  cpu_bus.iorq_n = 1'b0;
  cpu_bus.rd_n   = 1'b0;
  run_access(data);
endtask

// IORQ and M1 low together
task int_ack(output logic [7:0] data);
  cpu_bus.addr   = 16'($urandom);
  ula_data       = 8'($urandom);
  cpu_bus.iorq_n = 1'b0;
  cpu_bus.m1_n   = 1'b0;
  run_access(data);
endtask

// ----------------------------------------------------------------------------
// Compare
// ----------------------------------------------------------------------------
task check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
  end
endtask

`endif

// File: testbench/tb_zxuno_io.sv
`default_nettype none

module tb_zxuno_io;

  timeunit 1ns;
  timeprecision 100ps;

  import zxuno_pkg::*;

  localparam int unsigned drive_delay     = 1;
  localparam int unsigned options_timeout = 8;

  logic         sysclk;
  logic         reset;
  z80_io_bus_t  cpu_bus;
  logic [7:0]   ula_data;
  logic [7:0]   cpu_din;
  dev_options_t dev_options;

  // Reference model state
  logic [7:0]  m_regaddr;
  logic [7:0]  m_scratch;
  logic [7:0]  m_options;
  int unsigned m_idx;

  int unsigned errors;
  int unsigned checks;
  int unsigned tests;
  int unsigned test_base;
  string       test_name;

  zxuno_io u_zxuno_io (
    .sysclk      (sysclk),
    .reset       (reset),
    .cpu_bus     (cpu_bus),
    .ula_data    (ula_data),
    .cpu_din     (cpu_din),
    .dev_options (dev_options)
  );

  `include "tb_bus_tasks.svh"

  always #2 sysclk = ~sysclk;

  // --------------------------------------------------------------------------
  // Model-tracking accesses
  // --------------------------------------------------------------------------

  // Any address-port write also restarts the ID string
  task set_regaddr(input logic [7:0] value);
    io_write(zxuno_addr_port, value);
    m_regaddr = value;
    m_idx     = 0;
  endtask

  task write_data(input logic [7:0] value);
    io_write(zxuno_data_port, value);
    if (m_regaddr == reg_scratch) begin
      m_scratch = value;
    end else if (m_regaddr == reg_devoptions) begin
      m_options = value;
    end
  endtask

  task read_data_check();
    logic [7:0] got;
    logic [7:0] exp;
    io_read(zxuno_data_port, got);
    case (m_regaddr)
      reg_coreid: begin
        exp   = (m_idx == coreid_len) ? 8'h00 : coreid_text[m_idx];
        m_idx = (m_idx == coreid_len) ? 0 : m_idx + 1;
      end
      reg_scratch:    exp = m_scratch;
      reg_devoptions: exp = m_options;
      default:        exp = ula_data;
    endcase
    check_value($sformatf("data port, register %h", m_regaddr), got, exp);
  endtask

  task wait_options(input logic [7:0] exp);
    int unsigned cycles;
    cycles = 0;
    while (dev_options !== exp && cycles < options_timeout) begin
      @(posedge sysclk);
      #drive_delay;
      cycles++;
    end
    if (dev_options !== exp) begin
      errors++;
      $display("Timed out after %0d cycles waiting for dev_options to become %h",
               cycles, exp);
    end
  endtask

  // Each flag against its bit of the options byte
  task check_flags(input logic [7:0] opts);
    check_value("disable_spisd", {7'd0, dev_options.disable_spisd}, {7'd0, opts[7]});
    check_value("enable_timexmmu", {7'd0, dev_options.enable_timexmmu}, {7'd0, opts[6]});
    check_value("disable_romsel1f", {7'd0, dev_options.disable_romsel1f}, {7'd0, opts[5]});
    check_value("disable_romsel7f", {7'd0, dev_options.disable_romsel7f}, {7'd0, opts[4]});
    check_value("disable_1ffd", {7'd0, dev_options.disable_1ffd}, {7'd0, opts[3]});
    check_value("disable_7ffd", {7'd0, dev_options.disable_7ffd}, {7'd0, opts[2]});
    check_value("disable_turboay", {7'd0, dev_options.disable_turboay}, {7'd0, opts[1]});
    check_value("disable_ay", {7'd0, dev_options.disable_ay}, {7'd0, opts[0]});
  endtask

  task start_test(input string name);
    test_name = name;
    test_base = errors;
    tests++;
  endtask

  task end_test();
    if (errors == test_base) begin
      $display("%s: passed", test_name);
    end else begin
      $display("%s: %0d errors", test_name, errors - test_base);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    int unsigned seed;
    logic [7:0]  got;
    logic [7:0]  value;
    logic [15:0] port;
    seed = $urandom(32'hbbee);
    errors = 0;
    checks = 0;
    tests  = 0;
    sysclk   = 1'b0;
    reset    = 1'b1;
    ula_data = 8'h00;
    cpu_bus.addr  = 16'h0000;
    cpu_bus.wdata = 8'h00;
    bus_idle();
    m_regaddr = 8'h00;
    m_scratch = 8'h00;
    m_options = 8'h00;
    m_idx     = 0;
    repeat (4) @(posedge sysclk);
    #drive_delay;
    reset = 1'b0;

    start_test("reset values");
    check_value("dev_options", dev_options, 8'h00);
    io_read(zxuno_addr_port, got);
    check_value("address port", got, m_regaddr);
    set_regaddr(reg_scratch);
    read_data_check();
    set_regaddr(reg_devoptions);
    read_data_check();
    end_test();

    start_test("address port");
    repeat (20) begin
      set_regaddr(8'($urandom));
      io_read(zxuno_addr_port, got);
      check_value("address port", got, m_regaddr);
    end
    end_test();

    start_test("scratch and options");
    repeat (12) begin
      set_regaddr(reg_scratch);
      write_data(8'($urandom));
      read_data_check();
      set_regaddr(reg_devoptions);
      write_data(8'($urandom));
      wait_options(m_options);
      check_flags(m_options);
      read_data_check();
      set_regaddr(reg_scratch);
      read_data_check();
    end
    end_test();

    start_test("core id");
    set_regaddr(reg_coreid);
    repeat (2 * (coreid_len + 1) + 3) read_data_check();
    // Restart in the middle of the string
    set_regaddr(reg_coreid);
    repeat (coreid_len + 1) read_data_check();
    end_test();

    start_test("bus fallback");
    repeat (4) begin
      int_ack(got);
      check_value("interrupt acknowledge", got, 8'hFF);
    end
    repeat (8) begin
      port = 16'($urandom);
      if (port == zxuno_addr_port || port == zxuno_data_port) begin
        port = port ^ 16'h0001;
      end
      io_read(port, got);
      check_value($sformatf("unused port %h", port), got, ula_data);
    end
    repeat (6) begin
      value = 8'($urandom);
      if (value == reg_coreid || value == reg_scratch || value == reg_devoptions) begin
        value = value ^ 8'h10;
      end
      set_regaddr(value);
      read_data_check();
    end
    end_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+testbench
source/zxuno_pkg.sv
source/zxuno_addr_reg.sv
source/coreid_reader.sv
source/option_registers.sv
source/cpu_read_mux.sv
source/zxuno_io.sv
testbench/tb_zxuno_io.sv
